//--- source/opn2_pkg.sv
`default_nettype none

package opn2_pkg;

	// Bank 0 register addresses
	localparam logic [7:0] REG_TEST  = 8'h21; // Bit 6 debug read, bit 7 high byte
	localparam logic [7:0] REG_TA_HI = 8'h24;
	localparam logic [7:0] REG_TA_LO = 8'h25;
	localparam logic [7:0] REG_TB    = 8'h26;
	localparam logic [7:0] REG_CTRL  = 8'h27;
	localparam logic [7:0] REG_TEST2 = 8'h2C; // Bit 4 picks timer B for debug

	// Timer control bits in REG_CTRL
	localparam int CTRL_LOAD_A = 0;
	localparam int CTRL_LOAD_B = 1;
	localparam int CTRL_EN_A   = 2;
	localparam int CTRL_EN_B   = 3;
	localparam int CTRL_RST_A  = 4;
	localparam int CTRL_RST_B  = 5;

	localparam int TA_W = 10;
	localparam int TB_W = 8;

	localparam int BUSY_W = 5; // 32 c1 strobes

	// Status byte
	localparam int STAT_TA   = 0;
	localparam int STAT_TB   = 1;
	localparam int STAT_BUSY = 7;

endpackage

`default_nettype wire

//--- source/opn2_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

interface opn2_wr_if;

	logic       addr_we; // One cycle per address write
	logic       data_we; // One cycle per data write
	logic [7:0] wdata;
	logic       bank;    // Address pin 1 at write time

	modport io (
		output addr_we, data_we, wdata, bank
	);

	modport regs (
		input addr_we, data_we, wdata, bank
	);

endinterface

`default_nettype wire

//--- source/opn2_phase.sv
`timescale 1ns/1ps
`default_nettype none

module opn2_phase #(
	parameter int PHASE_DIV = 6
) (
	input  logic mclk_i,
	input  logic rst_n_i,
	output logic c1_o,
	output logic c2_o,
	output logic tick_o
);

	localparam int PW = (PHASE_DIV > 1) ? $clog2(PHASE_DIV) : 1;

	logic [PW-1:0] ph_cnt;
	logic [3:0]    tick_cnt;

	always_ff @(posedge mclk_i) begin
		if (!rst_n_i)
			ph_cnt <= '0;
		else if (ph_cnt == PW'(PHASE_DIV - 1))
			ph_cnt <= '0;
		else
			ph_cnt <= ph_cnt + PW'(1);
	end

	// One timer tick per ten c1
	always_ff @(posedge mclk_i) begin
		if (!rst_n_i)
			tick_cnt <= '0;
		else if (c1_o)
			tick_cnt <= (tick_cnt == 4'd9) ? 4'd0 : tick_cnt + 4'd1;
	end

	assign c1_o   = (ph_cnt == '0);
	assign c2_o   = (ph_cnt == PW'(PHASE_DIV / 2));
	assign tick_o = c1_o & (tick_cnt == 4'd9);

endmodule

`default_nettype wire

//--- source/opn2_io.sv
`timescale 1ns/1ps
`default_nettype none

module opn2_io (
	input  logic                      mclk_i,
	input  logic                      rst_n_i,
	input  logic                      c1_i,
	input  logic                      c2_i,
	input  logic                      cs_n_i,
	input  logic                      wr_n_i,
	input  logic                      rd_n_i,
	input  logic [1:0]                addr_i,
	input  logic [7:0]                data_i,
	opn2_wr_if.io                     wr,
	input  logic [7:6]                reg_21_i,
	input  logic [4:4]                reg_2c_i,
	input  logic [opn2_pkg::TA_W-1:0] ta_reload_i,
	input  logic [opn2_pkg::TB_W-1:0] tb_reload_i,
	input  logic                      ta_flag_i,
	input  logic                      tb_flag_i,
	output logic [7:0]                data_o,
	output logic                      io_dir_o,
	output logic                      irq_n_o
);

	logic                        wr_act;
	logic                        rd_act;
	logic [1:0]                  wr_req;   // Bit 0 address, bit 1 data
	logic [1:0]                  wr_flag;
	logic [1:0]                  wr_stage;
	logic [1:0]                  wr_sig;
	logic [1:0]                  wr_pulse;
	logic [8:0]                  wr_latch;
	logic                        busy_req;
	logic                        busy;
	logic [opn2_pkg::BUSY_W-1:0] busy_cnt;
	logic                        ta_stat;
	logic                        tb_stat;
	logic [7:0]                  status;
	logic [15:0]                 dbg_word;

	assign wr_act = ~cs_n_i & ~wr_n_i;
	assign rd_act = ~cs_n_i & ~rd_n_i;
	assign wr_req = {wr_act & addr_i[0], wr_act & ~addr_i[0]};

	// Write level -> set/reset flag -> c1 stage -> c2 sample, both chains at once
	always_ff @(posedge mclk_i) begin
		if (!rst_n_i) begin
			wr_flag  <= '0;
			wr_stage <= '0;
			wr_sig   <= '0;
		end else begin
			wr_flag <= wr_req | (wr_flag & ~wr_sig); // Released once seen on c2
			if (c1_i)
				wr_stage <= wr_flag;
			if (c2_i)
				wr_sig <= wr_stage;
		end
	end

	assign wr_pulse   = {2{c2_i}} & wr_stage & ~wr_sig; // Rising edge of the c2 sample
	assign wr.addr_we = wr_pulse[0];
	assign wr.data_we = wr_pulse[1];

	always_ff @(posedge mclk_i) begin
		if (wr_act)
			wr_latch <= {addr_i[1], data_i};
	end

	assign wr.wdata = wr_latch[7:0];
	assign wr.bank  = wr_latch[8];

	// Busy window after each data write
	always_ff @(posedge mclk_i) begin
		if (!rst_n_i) begin
			busy_req <= 1'b0;
			busy     <= 1'b0;
			busy_cnt <= '0;
		end else begin
			if (wr_pulse[1])
				busy_req <= 1'b1;
			else if (c2_i)
				busy_req <= 1'b0;

			if (c2_i && busy_req) begin
				busy     <= 1'b1; // Also restarts a running period
				busy_cnt <= '0;
			end else if (c1_i && busy) begin
				busy_cnt <= busy_cnt + opn2_pkg::BUSY_W'(1);
				if (&busy_cnt)
					busy <= 1'b0;
			end
		end
	end

	// Timer flags held still during a read
	always_ff @(posedge mclk_i) begin
		if (!rst_n_i) begin
			ta_stat <= 1'b0;
			tb_stat <= 1'b0;
		end else if (!rd_act) begin
			ta_stat <= ta_flag_i;
			tb_stat <= tb_flag_i;
		end
	end

	always_comb begin
		status                     = 8'h00;
		status[opn2_pkg::STAT_TA]   = ta_stat;
		status[opn2_pkg::STAT_TB]   = tb_stat;
		status[opn2_pkg::STAT_BUSY] = busy;
	end

	assign dbg_word = reg_2c_i[4] ? {{(16 - opn2_pkg::TB_W){1'b0}}, tb_reload_i}
	                              : {{(16 - opn2_pkg::TA_W){1'b0}}, ta_reload_i};

	always_comb begin
		if (!rd_act)
			data_o = 8'h00;
		else if (reg_21_i[6])
			data_o = reg_21_i[7] ? dbg_word[15:8] : dbg_word[7:0];
		else
			data_o = status;
	end

	assign io_dir_o = ~rd_act; // High means input
	assign irq_n_o  = ~(ta_stat | tb_stat);

endmodule

`default_nettype wire

//--- source/opn2_regs.sv
`timescale 1ns/1ps
`default_nettype none

module opn2_regs (
	input  logic                      mclk_i,
	input  logic                      rst_n_i,
	opn2_wr_if.regs                   wr,
	output logic [7:6]                reg_21_o,
	output logic [4:4]                reg_2c_o,
	output logic [opn2_pkg::TA_W-1:0] ta_reload_o,
	output logic [opn2_pkg::TB_W-1:0] tb_reload_o,
	output logic                      load_a_o,
	output logic                      load_b_o,
	output logic                      en_a_o,
	output logic                      en_b_o,
	output logic                      rst_a_o,
	output logic                      rst_b_o
);

	logic [7:0] idx;
	logic       idx_vld; // Bank 1 addresses are not decoded here

	always_ff @(posedge mclk_i) begin
		if (!rst_n_i) begin
			idx     <= 8'h00;
			idx_vld <= 1'b0;
		end else if (wr.addr_we) begin
			idx     <= wr.wdata;
			idx_vld <= ~wr.bank;
		end
	end

	always_ff @(posedge mclk_i) begin
		if (!rst_n_i) begin
			reg_21_o    <= '0;
			reg_2c_o    <= '0;
			ta_reload_o <= '0;
			tb_reload_o <= '0;
			load_a_o    <= 1'b0;
			load_b_o    <= 1'b0;
			en_a_o      <= 1'b0;
			en_b_o      <= 1'b0;
			rst_a_o     <= 1'b0;
			rst_b_o     <= 1'b0;
		end else begin
			rst_a_o <= 1'b0; // Flag resets last one cycle
			rst_b_o <= 1'b0;
			if (wr.data_we && idx_vld) begin
				case (idx)
					opn2_pkg::REG_TEST:  reg_21_o <= wr.wdata[7:6];
					opn2_pkg::REG_TA_HI: ta_reload_o[9:2] <= wr.wdata;
					opn2_pkg::REG_TA_LO: ta_reload_o[1:0] <= wr.wdata[1:0];
					opn2_pkg::REG_TB:    tb_reload_o <= wr.wdata;
					opn2_pkg::REG_CTRL: begin
						load_a_o <= wr.wdata[opn2_pkg::CTRL_LOAD_A];
						load_b_o <= wr.wdata[opn2_pkg::CTRL_LOAD_B];
						en_a_o   <= wr.wdata[opn2_pkg::CTRL_EN_A];
						en_b_o   <= wr.wdata[opn2_pkg::CTRL_EN_B];
						rst_a_o  <= wr.wdata[opn2_pkg::CTRL_RST_A];
						rst_b_o  <= wr.wdata[opn2_pkg::CTRL_RST_B];
					end
					opn2_pkg::REG_TEST2: reg_2c_o <= wr.wdata[4:4];
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- source/opn2_timers.sv
`timescale 1ns/1ps
`default_nettype none

module opn2_timers #(
	parameter int TB_PRESCALE = 16
) (
	input  logic                      mclk_i,
	input  logic                      rst_n_i,
	input  logic                      tick_i,
	input  logic                      load_a_i,
	input  logic                      load_b_i,
	input  logic                      en_a_i,
	input  logic                      en_b_i,
	input  logic                      rst_a_i,
	input  logic                      rst_b_i,
	input  logic [opn2_pkg::TA_W-1:0] ta_reload_i,
	input  logic [opn2_pkg::TB_W-1:0] tb_reload_i,
	output logic                      ta_flag_o,
	output logic                      tb_flag_o
);

	localparam int PRE_W = (TB_PRESCALE > 1) ? $clog2(TB_PRESCALE) : 1;

	logic [PRE_W-1:0] pre_cnt;
	logic             tb_tick;
	logic [1:0]       flag;

	assign tb_tick = tick_i & (pre_cnt == PRE_W'(TB_PRESCALE - 1));

	always_ff @(posedge mclk_i) begin
		if (!rst_n_i)
			pre_cnt <= '0;
		else if (tb_tick)
			pre_cnt <= '0;
		else if (tick_i)
			pre_cnt <= pre_cnt + PRE_W'(1);
	end

	// Timer A in slot 0, timer B in slot 1
	for (genvar i = 0; i < 2; i++) begin : g_tmr
		localparam int W = (i == 0) ? opn2_pkg::TA_W : opn2_pkg::TB_W;

		logic [W-1:0] cnt;
		logic [W-1:0] reload;
		logic         load;
		logic         en;
		logic         clr;
		logic         step;
		logic         load_q;
		logic         flag_q;
		logic         ovf;

		if (i == 0) begin : g_a
			assign reload = ta_reload_i;
			assign load   = load_a_i;
			assign en     = en_a_i;
			assign clr    = rst_a_i;
			assign step   = tick_i;
		end else begin : g_b
			assign reload = tb_reload_i;
			assign load   = load_b_i;
			assign en     = en_b_i;
			assign clr    = rst_b_i;
			assign step   = tb_tick;
		end

		assign ovf = load & step & (&cnt);

		always_ff @(posedge mclk_i) begin
			if (!rst_n_i) begin
				cnt    <= '0;
				load_q <= 1'b0;
				flag_q <= 1'b0;
			end else begin
				load_q <= load;
				if ((load && !load_q) || ovf)
					cnt <= reload; // Start or wrap
				else if (load && step)
					cnt <= cnt + W'(1);
				if (clr)
					flag_q <= 1'b0;
				else if (ovf && en)
					flag_q <= 1'b1;
			end
		end

		assign flag[i] = flag_q;
	end

	assign ta_flag_o = flag[0];
	assign tb_flag_o = flag[1];

endmodule

`default_nettype wire

//--- source/opn2_top.sv
`timescale 1ns/1ps
`default_nettype none

module opn2_top #(
	parameter int PHASE_DIV   = 6,
	parameter int TB_PRESCALE = 16
) (
	input  logic       mclk_i,
	input  logic       rst_n_i,
	input  logic       cs_n_i,
	input  logic       wr_n_i,
	input  logic       rd_n_i,
	input  logic [1:0] addr_i,
	input  logic [7:0] data_i,
	output logic [7:0] data_o,
	output logic       io_dir_o,
	output logic       irq_n_o
);

	logic                      c1;
	logic                      c2;
	logic                      tick;
	logic [7:6]                reg_21;
	logic [4:4]                reg_2c;
	logic [opn2_pkg::TA_W-1:0] ta_reload;
	logic [opn2_pkg::TB_W-1:0] tb_reload;
	logic                      load_a;
	logic                      load_b;
	logic                      en_a;
	logic                      en_b;
	logic                      rst_a;
	logic                      rst_b;
	logic                      ta_flag;
	logic                      tb_flag;

	opn2_wr_if wr_bus ();

	opn2_phase #(.PHASE_DIV(PHASE_DIV)) i_phase (
		.mclk_i(mclk_i), .rst_n_i(rst_n_i),
		.c1_o(c1), .c2_o(c2), .tick_o(tick)
	);

	opn2_io i_io (
		.mclk_i(mclk_i), .rst_n_i(rst_n_i), .c1_i(c1), .c2_i(c2),
		.cs_n_i(cs_n_i), .wr_n_i(wr_n_i), .rd_n_i(rd_n_i),
		.addr_i(addr_i), .data_i(data_i), .wr(wr_bus.io),
		.reg_21_i(reg_21), .reg_2c_i(reg_2c),
		.ta_reload_i(ta_reload), .tb_reload_i(tb_reload),
		.ta_flag_i(ta_flag), .tb_flag_i(tb_flag),
		.data_o(data_o), .io_dir_o(io_dir_o), .irq_n_o(irq_n_o)
	);

	opn2_regs i_regs (
		.mclk_i(mclk_i), .rst_n_i(rst_n_i), .wr(wr_bus.regs),
		.reg_21_o(reg_21), .reg_2c_o(reg_2c),
		.ta_reload_o(ta_reload), .tb_reload_o(tb_reload),
		.load_a_o(load_a), .load_b_o(load_b), .en_a_o(en_a), .en_b_o(en_b),
		.rst_a_o(rst_a), .rst_b_o(rst_b)
	);

	opn2_timers #(.TB_PRESCALE(TB_PRESCALE)) i_timers (
		.mclk_i(mclk_i), .rst_n_i(rst_n_i), .tick_i(tick),
		.load_a_i(load_a), .load_b_i(load_b), .en_a_i(en_a), .en_b_i(en_b),
		.rst_a_i(rst_a), .rst_b_i(rst_b),
		.ta_reload_i(ta_reload), .tb_reload_i(tb_reload),
		.ta_flag_o(ta_flag), .tb_flag_o(tb_flag)
	);

endmodule

`default_nettype wire

//--- test/opn2_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module opn2_asserts (
	input  logic       mclk_i,
	input  logic       rst_n_i,
	input  logic [1:0] wr_pulse_i,
	input  logic       ta_flag_i,
	input  logic       tb_flag_i,
	input  logic       cs_n_i,
	input  logic       rd_n_i,
	input  logic       io_dir_i,
	input  logic       irq_n_i
);

	int n_strobe = 0;
	int n_irq    = 0;
	int n_dir    = 0;
	int fail_cnt;

	assign fail_cnt = n_strobe + n_irq + n_dir;

	a_one_strobe: assert property (@(posedge mclk_i) disable iff (!rst_n_i) !(&wr_pulse_i))
		else begin
			n_strobe++;
			$error("Address and data write strobes high in the same cycle");
		end

	// Interrupt follows the timer flags one cycle later outside reads
	a_irq: assert property (@(posedge mclk_i) disable iff (!rst_n_i)
		(cs_n_i || rd_n_i) |=> irq_n_i == !($past(ta_flag_i) || $past(tb_flag_i)))
		else begin
			n_irq++;
			$error("irq_n_o does not match the timer flags");
		end

	a_dir: assert property (@(posedge mclk_i) disable iff (!rst_n_i)
		!io_dir_i |-> (!cs_n_i && !rd_n_i))
		else begin
			n_dir++;
			$error("Data pins driven outside a read");
		end

endmodule

bind opn2_io opn2_asserts i_asserts (
	.mclk_i(mclk_i), .rst_n_i(rst_n_i), .wr_pulse_i(wr_pulse),
	.ta_flag_i(ta_flag_i), .tb_flag_i(tb_flag_i), .cs_n_i(cs_n_i), .rd_n_i(rd_n_i),
	.io_dir_i(io_dir_o), .irq_n_i(irq_n_o)
);

`default_nettype wire

//--- test/opn2_checker.sv
`timescale 1ns/1ps
`default_nettype none

module opn2_checker (
	input  logic       mclk_i,
	input  logic       chk_i,
	input  logic [1:0] sel_i,      // 0 data_o, 1 irq_n_o, 2 io_dir_o
	input  logic [7:0] mask_i,
	input  logic [7:0] exp_i,
	input  logic       test_done_i,
	input  logic [7:0] test_num_i,
	input  logic       fin_i,
	input  logic [7:0] data_i,
	input  logic       irq_n_i,
	input  logic       io_dir_i,
	output int         err_cnt_o
);

	int cur_test = 1;
	int chk_cnt  = 0;
	int err_cnt  = 0;
	int test_err = 0;
	int test_cnt = 0;
	int test_bad = 0;

	assign err_cnt_o = err_cnt;

	// Outputs settle by the falling edge
	always @(negedge mclk_i) begin
		if (chk_i) begin
			chk_cnt++;
			if (sel_i == 2'd0 && (data_i & mask_i) != exp_i) begin
				$display("Error: test %0d data_o = %02h (mask %02h), expected %02h",
				         cur_test, data_i & mask_i, mask_i, exp_i);
				test_err++;
			end else if (sel_i == 2'd1 && irq_n_i != exp_i[0]) begin
				$display("Error: test %0d irq_n_o = %0h, expected %0h", cur_test, irq_n_i, exp_i[0]);
				test_err++;
			end else if (sel_i == 2'd2 && io_dir_i != exp_i[0]) begin
				$display("Error: test %0d io_dir_o = %0h, expected %0h", cur_test, io_dir_i,
				         exp_i[0]);
				test_err++;
			end
		end
		if (test_done_i) begin
			test_cnt++;
			if (test_err == 0) begin
				$display("Test %0d ok", test_num_i);
			end else begin
				$display("Test %0d failed with %0d errors", test_num_i, test_err);
				test_bad++;
			end
			err_cnt += test_err;
			test_err = 0;
			cur_test = int'(test_num_i) + 1;
		end
		if (fin_i) begin
			err_cnt += test_err; // An unfinished test still counts
			test_err = 0;
			$display("Tests %0d, failed %0d, checks %0d, errors %0d", test_cnt, test_bad, chk_cnt,
			         err_cnt);
		end
	end

endmodule

`default_nettype wire

//--- test/opn2_tb.sv
`timescale 1ns/1ps
`default_nettype none

module opn2_tb;

	localparam int PHASE_DIV   = 6;
	localparam int TB_PRESCALE = 16;
	localparam int STROBE_LIM  = 2 * PHASE_DIV + 4;
	localparam int BUSY_LIM    = 40 * PHASE_DIV;
	localparam int FLAG_LIM    = 4 * TB_PRESCALE * 10 * PHASE_DIV;

	localparam logic [2:0] OP_WR   = 3'd0; // Address write, then data write
	localparam logic [2:0] OP_RD   = 3'd1;
	localparam logic [2:0] OP_POLL = 3'd2; // Read until the masked bits match
	localparam logic [2:0] OP_IRQ  = 3'd3;
	localparam logic [2:0] OP_DIR  = 3'd4;
	localparam logic [2:0] OP_END  = 3'd5;

	typedef struct packed {
		logic [2:0]  op;
		logic        bank;
		logic [7:0]  idx;  // Register index or test number for OP_END
		logic [7:0]  val;
		logic [7:0]  mask;
		logic [7:0]  exp;
		logic [15:0] lim;
	} step_t;

	logic       mclk = 1'b0;
	logic       rst_n;
	logic       cs_n;
	logic       wr_n;
	logic       rd_n;
	logic [1:0] addr;
	logic [7:0] wdata;
	logic [7:0] rdata;
	logic       io_dir;
	logic       irq_n;
	logic       chk;
	logic [1:0] chk_sel;
	logic [7:0] chk_mask;
	logic [7:0] chk_exp;
	logic       test_done;
	logic [7:0] test_num;
	logic       fin;
	int         err_cnt;
	bit         aborted = 1'b0;
	integer     seed;
	int         step_i;
	step_t      steps[$];

	opn2_top #(.PHASE_DIV(PHASE_DIV), .TB_PRESCALE(TB_PRESCALE)) i_opn2_top (
		.mclk_i(mclk), .rst_n_i(rst_n), .cs_n_i(cs_n), .wr_n_i(wr_n), .rd_n_i(rd_n),
		.addr_i(addr), .data_i(wdata), .data_o(rdata), .io_dir_o(io_dir), .irq_n_o(irq_n)
	);

	opn2_checker i_checker (
		.mclk_i(mclk), .chk_i(chk), .sel_i(chk_sel), .mask_i(chk_mask), .exp_i(chk_exp),
		.test_done_i(test_done), .test_num_i(test_num), .fin_i(fin),
		.data_i(rdata), .irq_n_i(irq_n), .io_dir_i(io_dir), .err_cnt_o(err_cnt)
	);

	always #50 mclk = ~mclk;

	task automatic add_step(input logic [2:0] op, input logic bank, input logic [7:0] idx,
	                        input logic [7:0] val, input logic [7:0] mask,
	                        input logic [7:0] exp, input int lim);
		step_t s;
		s.op   = op;
		s.bank = bank;
		s.idx  = idx;
		s.val  = val;
		s.mask = mask;
		s.exp  = exp;
		s.lim  = lim[15:0];
		steps.push_back(s);
	endtask

	task automatic build_table();
		logic [7:0] ta_hi;
		logic [7:0] ta_lo;
		logic [7:0] tb_val;
		logic [9:0] ta;
		integer     r;
		seed   = 72;
		r      = $random(seed);
		ta_hi  = r[7:0];
		r      = $random(seed);
		ta_lo  = r[7:0];
		r      = $random(seed);
		tb_val = r[7:0];
		ta     = {ta_hi, ta_lo[1:0]}; // 0x24 holds bits 9..2, 0x25 bits 1..0
		// Reset state
		add_step(OP_RD, 1'b0, 8'h00, 8'h00, 8'hFF, 8'h00, 0);
		add_step(OP_IRQ, 1'b0, 8'h00, 8'h00, 8'h01, 8'h01, 0);
		add_step(OP_DIR, 1'b0, 8'h00, 8'h00, 8'h01, 8'h01, 0);
		add_step(OP_END, 1'b0, 8'd1, 8'h00, 8'h00, 8'h00, 0);
		// Debug readback of both reload values
		add_step(OP_WR, 1'b0, opn2_pkg::REG_TA_HI, ta_hi, 8'h00, 8'h00, 0);
		add_step(OP_WR, 1'b0, opn2_pkg::REG_TA_LO, ta_lo, 8'h00, 8'h00, 0);
		add_step(OP_WR, 1'b0, opn2_pkg::REG_TB, tb_val, 8'h00, 8'h00, 0);
		add_step(OP_WR, 1'b0, opn2_pkg::REG_TEST2, 8'h00, 8'h00, 8'h00, 0);
		add_step(OP_WR, 1'b0, opn2_pkg::REG_TEST, 8'h40, 8'h00, 8'h00, 0);
		add_step(OP_RD, 1'b0, 8'h00, 8'h00, 8'hFF, ta[7:0], 0);
		add_step(OP_WR, 1'b0, opn2_pkg::REG_TEST, 8'hC0, 8'h00, 8'h00, 0);
		add_step(OP_RD, 1'b0, 8'h00, 8'h00, 8'hFF, {6'd0, ta[9:8]}, 0);
		add_step(OP_WR, 1'b0, opn2_pkg::REG_TEST2, 8'h10, 8'h00, 8'h00, 0);
		add_step(OP_RD, 1'b0, 8'h00, 8'h00, 8'hFF, 8'h00, 0);
		add_step(OP_WR, 1'b0, opn2_pkg::REG_TEST, 8'h40, 8'h00, 8'h00, 0);
		add_step(OP_RD, 1'b0, 8'h00, 8'h00, 8'hFF, tb_val, 0);
		add_step(OP_END, 1'b0, 8'd2, 8'h00, 8'h00, 8'h00, 0);
		// Bank 1 writes must not reach bank 0 registers
		add_step(OP_WR, 1'b1, opn2_pkg::REG_TB, ~tb_val, 8'h00, 8'h00, 0);
		add_step(OP_WR, 1'b1, opn2_pkg::REG_TEST, 8'h00, 8'h00, 8'h00, 0);
		add_step(OP_RD, 1'b0, 8'h00, 8'h00, 8'hFF, tb_val, 0);
		add_step(OP_END, 1'b0, 8'd3, 8'h00, 8'h00, 8'h00, 0);
		// Busy window with debug read off
		add_step(OP_WR, 1'b0, opn2_pkg::REG_TEST, 8'h00, 8'h00, 8'h00, 0);
		add_step(OP_RD, 1'b0, 8'h00, 8'h00, 8'h80, 8'h80, 0);
		add_step(OP_POLL, 1'b0, 8'h00, 8'h00, 8'h80, 8'h00, BUSY_LIM);
		add_step(OP_RD, 1'b0, 8'h00, 8'h00, 8'h80, 8'h00, 0);
		add_step(OP_END, 1'b0, 8'd4, 8'h00, 8'h00, 8'h00, 0);
		// Timer A loaded from 0x3FE and enabled
		add_step(OP_WR, 1'b0, opn2_pkg::REG_TA_HI, 8'hFF, 8'h00, 8'h00, 0);
		add_step(OP_WR, 1'b0, opn2_pkg::REG_TA_LO, 8'h02, 8'h00, 8'h00, 0);
		add_step(OP_WR, 1'b0, opn2_pkg::REG_CTRL, 8'h05, 8'h00, 8'h00, 0);
		add_step(OP_POLL, 1'b0, 8'h00, 8'h00, 8'h01, 8'h01, FLAG_LIM);
		add_step(OP_RD, 1'b0, 8'h00, 8'h00, 8'h01, 8'h01, 0);
		add_step(OP_IRQ, 1'b0, 8'h00, 8'h00, 8'h01, 8'h00, 0);
		add_step(OP_END, 1'b0, 8'd5, 8'h00, 8'h00, 8'h00, 0);
		add_step(OP_WR, 1'b0, opn2_pkg::REG_CTRL, 8'h10, 8'h00, 8'h00, 0);
		add_step(OP_RD, 1'b0, 8'h00, 8'h00, 8'h01, 8'h00, 0);
		add_step(OP_IRQ, 1'b0, 8'h00, 8'h00, 8'h01, 8'h01, 0);
		add_step(OP_END, 1'b0, 8'd6, 8'h00, 8'h00, 8'h00, 0);
		// Timer B from 0xFE
		add_step(OP_WR, 1'b0, opn2_pkg::REG_TB, 8'hFE, 8'h00, 8'h00, 0);
		add_step(OP_WR, 1'b0, opn2_pkg::REG_CTRL, 8'h0A, 8'h00, 8'h00, 0);
		add_step(OP_POLL, 1'b0, 8'h00, 8'h00, 8'h02, 8'h02, FLAG_LIM);
		add_step(OP_RD, 1'b0, 8'h00, 8'h00, 8'h02, 8'h02, 0);
		add_step(OP_IRQ, 1'b0, 8'h00, 8'h00, 8'h01, 8'h00, 0);
		add_step(OP_END, 1'b0, 8'd7, 8'h00, 8'h00, 8'h00, 0);
		add_step(OP_WR, 1'b0, opn2_pkg::REG_CTRL, 8'h20, 8'h00, 8'h00, 0);
		add_step(OP_RD, 1'b0, 8'h00, 8'h00, 8'h03, 8'h00, 0);
		add_step(OP_IRQ, 1'b0, 8'h00, 8'h00, 8'h01, 8'h01, 0);
		add_step(OP_END, 1'b0, 8'd8, 8'h00, 8'h00, 8'h00, 0);
	endtask

	// Holds the write for at least 2*PHASE_DIV cycles and until the internal strobe shows
	task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
		int n;
		bit seen = 1'b0;
		@(posedge mclk);
		addr  <= a;
		wdata <= d;
		cs_n  <= 1'b0;
		wr_n  <= 1'b0;
		for (n = 0; n < STROBE_LIM && !seen; n++) begin
			@(negedge mclk);
			seen = a[0] ? i_opn2_top.wr_bus.data_we : i_opn2_top.wr_bus.addr_we;
		end
		if (!seen) begin
			$display("Timeout: no write strobe for bus address %0d", a);
			aborted = 1'b1;
		end
		while (n < 2 * PHASE_DIV) begin
			@(negedge mclk);
			n++;
		end
		@(posedge mclk);
		cs_n <= 1'b1;
		wr_n <= 1'b1;
		repeat (2 * PHASE_DIV) @(posedge mclk); // Chain clears and busy rises
	endtask

	task automatic bus_read(input bit check, input logic [7:0] mask, input logic [7:0] exp,
	                        output logic [7:0] v);
		int n;
		bit act = 1'b0;
		@(posedge mclk);
		cs_n     <= 1'b0;
		rd_n     <= 1'b0;
		chk      <= check;
		chk_sel  <= 2'd0;
		chk_mask <= mask;
		chk_exp  <= exp;
		for (n = 0; n < 4 && !act; n++) begin
			@(negedge mclk);
			act = !io_dir;
		end
		v = rdata;
		if (!act) begin
			$display("Timeout: data pins never turned to output during a read");
			aborted = 1'b1;
		end
		@(posedge mclk);
		cs_n <= 1'b1;
		rd_n <= 1'b1;
		chk  <= 1'b0;
	endtask

	task automatic pin_check(input logic [1:0] sel, input logic e);
		@(posedge mclk);
		chk      <= 1'b1;
		chk_sel  <= sel;
		chk_mask <= 8'h01;
		chk_exp  <= {7'd0, e};
		@(posedge mclk);
		chk <= 1'b0;
	endtask

	task automatic end_test(input logic [7:0] t);
		@(posedge mclk);
		test_done <= 1'b1;
		test_num  <= t;
		@(posedge mclk);
		test_done <= 1'b0;
	endtask

	task automatic run_step(input step_t s);
		logic [7:0] v;
		int         n;
		case (s.op)
			OP_WR: begin
				bus_write({s.bank, 1'b0}, s.idx);
				if (!aborted)
					bus_write({s.bank, 1'b1}, s.val);
			end
			OP_RD:  bus_read(1'b1, s.mask, s.exp, v);
			OP_POLL: begin
				bus_read(1'b0, s.mask, s.exp, v);
				for (n = 2; (v & s.mask) != s.exp && n < int'(s.lim) && !aborted; n += 2)
					bus_read(1'b0, s.mask, s.exp, v);
				if ((v & s.mask) != s.exp && !aborted) begin
					$display("Timeout: status bits %02h never reached %02h", s.mask, s.exp);
					aborted = 1'b1;
				end
			end
			OP_IRQ: pin_check(2'd1, s.exp[0]);
			OP_DIR: pin_check(2'd2, s.exp[0]);
			default: end_test(s.idx);
		endcase
	endtask

	initial begin
		rst_n     <= 1'b0;
		cs_n      <= 1'b1;
		wr_n      <= 1'b1;
		rd_n      <= 1'b1;
		addr      <= 2'd0;
		wdata     <= 8'h00;
		chk       <= 1'b0;
		chk_sel   <= 2'd0;
		chk_mask  <= 8'h00;
		chk_exp   <= 8'h00;
		test_done <= 1'b0;
		test_num  <= 8'h00;
		fin       <= 1'b0;
		build_table();
		repeat (5) @(posedge mclk);
		rst_n <= 1'b1;
		for (step_i = 0; step_i < steps.size() && !aborted; step_i++)
			run_step(steps[step_i]);
		@(posedge mclk);
		fin <= 1'b1;
		@(posedge mclk);
		fin <= 1'b0;
		@(posedge mclk);
		if (aborted || err_cnt != 0 || i_opn2_top.i_io.i_asserts.fail_cnt != 0)
			$display(">>> FAIL");
		else
			$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
source/opn2_pkg.sv
source/opn2_wr_if.sv
source/opn2_phase.sv
source/opn2_io.sv
source/opn2_regs.sv
source/opn2_timers.sv
source/opn2_top.sv
test/opn2_asserts.sv
test/opn2_checker.sv
test/opn2_tb.sv

//--- Makefile
TOP := opn2_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
